// File: tests/exe_tests.txt
# name unit op rs1 rs2 rd data_rs1 data_rs2 imm pc use_imm use_pc size unsigned
# byp_valid byp_rd byp_data kill exp_result_rd exp_result_pc exp_taken (all hex)
add 0 0 1 2 3 5 7 0 0 0 0 0 0 0 0 0 0 c 0 0
sub 0 1 1 2 3 3 5 0 0 0 0 0 0 0 0 0 0 fffffffe 0 0
sra_imm 0 7 1 2 3 80000000 ffffffff 4 0 1 0 0 0 0 0 0 0 f8000000 0 0
slt 0 8 1 2 3 ffffffff 1 0 0 0 0 0 0 0 0 0 0 1 0 0
auipc 0 b 0 0 3 dead 0 12345000 1000 1 1 0 0 0 0 0 0 12346000 0 0
lui 0 a 0 0 3 0 0 abcde000 0 1 0 0 0 0 0 0 0 abcde000 0 0
byp_rs1 0 0 5 6 7 1 2 0 0 0 0 0 0 1 5 100 0 102 0 0
byp_x0 0 0 0 6 7 10 3 0 0 0 0 0 0 1 0 999 0 13 0 0
mul 1 c 1 2 3 ffffffff 7 0 0 0 0 0 0 0 0 0 0 fffffff9 0 0
mulh 1 d 1 2 3 ffffffff 7 0 0 0 0 0 0 0 0 0 0 ffffffff 0 0
mulhu 1 e 1 2 3 ffffffff ffffffff 0 0 0 0 0 0 0 0 0 0 fffffffe 0 0
mulhsu 1 f 1 2 3 80000000 ffffffff 0 0 0 0 0 0 0 0 0 0 80000000 0 0
div 2 10 1 2 3 ffffffec 3 0 0 0 0 0 0 0 0 0 0 fffffffa 0 0
rem 2 12 1 2 3 ffffffec 3 0 0 0 0 0 0 0 0 0 0 fffffffe 0 0
divu 2 11 1 2 3 64 7 0 0 0 0 0 0 0 0 0 0 e 0 0
div_zero 2 10 1 2 3 1234 0 0 0 0 0 0 0 0 0 0 0 ffffffff 0 0
rem_zero 2 12 1 2 3 1234 0 0 0 0 0 0 0 0 0 0 0 1234 0 0
div_ovf 2 10 1 2 3 80000000 ffffffff 0 0 0 0 0 0 0 0 0 0 80000000 0 0
beq 3 14 1 2 1 5 5 10 100 0 0 0 0 0 0 0 0 104 110 1
bne 3 15 1 2 1 5 5 10 100 0 0 0 0 0 0 0 0 104 104 0
blt 3 16 1 2 1 ffffffff 1 fffffff0 200 0 0 0 0 0 0 0 0 204 1f0 1
jal 3 1a 0 0 1 0 0 20 400 0 0 0 0 0 0 0 0 404 420 1
jalr 3 1b 5 0 1 1001 0 6 500 0 0 0 0 0 0 0 0 504 1006 1
sw 4 1d 1 2 0 100 8badf00d 0 0 0 0 2 0 0 0 0 0 0 0 0
lw 4 1c 1 0 3 100 0 0 0 0 0 2 0 0 0 0 0 8badf00d 0 0
lb 4 1c 1 0 3 100 0 1 0 0 0 0 0 0 0 0 0 fffffff0 0 0
lbu 4 1c 1 0 3 100 0 1 0 0 0 0 1 0 0 0 0 f0 0 0
lh 4 1c 1 0 3 100 0 2 0 0 0 1 0 0 0 0 0 ffff8bad 0 0
lhu 4 1c 1 0 3 100 0 2 0 0 0 1 1 0 0 0 0 8bad 0 0
sb 4 1d 1 2 0 100 aa 3 0 0 0 0 0 0 0 0 0 0 0 0
lw_sb 4 1c 1 0 3 100 0 0 0 0 0 2 0 0 0 0 0 aaadf00d 0 0
kill_div 2 10 1 2 3 64 7 0 0 0 0 0 0 0 0 0 1 0 0 0
after_kill 0 0 1 2 3 1 1 0 0 0 0 0 0 0 0 0 0 2 0 0

// File: files.f
design/exe_pkg.sv
design/alu.sv
design/branch_unit.sv
design/mul_unit.sv
design/div_unit.sv
design/lsu_wb.sv
design/exe_top.sv
design/dmem_wb.sv
design/exe_subsys.sv
tests/exe_props.sv
tests/exe_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module exe_tb \
		-Mdir obj_dir -f files.f
	./obj_dir/Vexe_tb 2>&1 | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/exe_tb.sv
module exe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import exe_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic          clk_i;
    logic          rst_i;
    logic          kill_i;
    rr_exe_instr_t from_rr_i;
    wb_exe_instr_t from_wb_i;
    exe_wb_instr_t to_wb_o;
    logic          stall_o;

    int tests_run;
    int tests_failed;
    int errors;

    exe_subsys #(
        .DMEM_WORDS (256)
    ) u_exe_subsys (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .kill_i    (kill_i),
        .from_rr_i (from_rr_i),
        .from_wb_i (from_wb_i),
        .to_wb_o   (to_wb_o),
        .stall_o   (stall_o)
    );

    always #2 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input string what,
                              input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAIL %s %s expected %08h actual %08h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_idx(input string name, input string what,
                             input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("FAIL %s %s expected %0d actual %0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s %s expected %b actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("FAIL %s latency expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // Multicycle units hold the stage in the first cycle
    function automatic logic expect_stall(input unit_e unit);
        return unit == UNIT_MUL || unit == UNIT_DIV || unit == UNIT_MEM;
    endfunction

    // Cycles from issue to result for a unit that starts idle
    function automatic int expect_latency(input unit_e unit, input word_t divisor);
        case (unit)
            UNIT_MUL: return 33;
            UNIT_DIV: return (divisor == '0) ? 1 : 33;
            UNIT_MEM: return 2;
            default:  return 0;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Stimulus and waits
    // ------------------------------------------------------------------
    task automatic drive_instr(input word_t fld [20]);
        from_rr_i.valid        = 1'b1;
        from_rr_i.unit         = unit_e'(fld[0][2:0]);
        from_rr_i.op           = op_e'(fld[1][4:0]);
        from_rr_i.rs1          = fld[2][4:0];
        from_rr_i.rs2          = fld[3][4:0];
        from_rr_i.rd           = fld[4][4:0];
        from_rr_i.data_rs1     = fld[5];
        from_rr_i.data_rs2     = fld[6];
        from_rr_i.imm          = fld[7];
        from_rr_i.pc           = fld[8];
        from_rr_i.use_imm      = fld[9][0];
        from_rr_i.use_pc       = fld[10][0];
        from_rr_i.mem_size     = mem_size_e'(fld[11][1:0]);
        from_rr_i.mem_unsigned = fld[12][0];
        from_wb_i.valid        = fld[13][0];
        from_wb_i.rd           = fld[14][4:0];
        from_wb_i.data         = fld[15];
    endtask

    // Outputs sampled at the falling edge
    task automatic wait_complete(output logic ok, output logic first_stall,
                                 output int latency);
        int cycles;
        ok          = 1'b0;
        first_stall = 1'b0;
        latency     = 0;
        cycles      = 0;
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            if (cycles == 0) begin
                first_stall = stall_o;
            end
            if (to_wb_o.valid && !stall_o) begin
                ok      = 1'b1;
                latency = cycles;
            end
            cycles++;
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int    fd;
        int    code;
        int    latency;
        string line;
        string name;
        word_t fld [20];
        logic  ok;
        logic  first_stall;
        logic  abort;

        clk_i        = 1'b0;
        rst_i        = 1'b1;
        kill_i       = 1'b0;
        from_rr_i    = '0;
        from_wb_i    = '0;
        tests_run    = 0;
        tests_failed = 0;
        abort        = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        fd = $fopen("tests/exe_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tests/exe_tests.txt");
            tests_failed++;
            abort = 1'b1;
        end

        while (!abort && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code <= 1 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                fld[14], fld[15], fld[16], fld[17], fld[18], fld[19]);
            if (code != 21) begin
                $display("Malformed vector line: %s", line);
                tests_failed++;
                continue;
            end

            errors = 0;
            tests_run++;
            @(posedge clk_i);
            #1;
            drive_instr(fld);

            if (fld[16][0]) begin
                // Abort in the second cycle, the instruction is flushed with it
                @(negedge clk_i);
                check_bit(name, "stall", 1'b1, stall_o);
                @(posedge clk_i);
                #1;
                kill_i          = 1'b1;
                from_rr_i.valid = 1'b0;
                @(posedge clk_i);
                #1;
                kill_i = 1'b0;
                // Reissued, a unit left running would finish early
                from_rr_i.valid = 1'b1;
                wait_complete(ok, first_stall, latency);
                if (!ok) begin
                    $display("Timeout: stall stayed high after kill in test %s", name);
                end else begin
                    check_latency(name, expect_latency(unit_e'(fld[0][2:0]), fld[6]),
                                  latency);
                end
            end else begin
                wait_complete(ok, first_stall, latency);
                if (!ok) begin
                    $display("Timeout: test %s did not complete within %0d cycles",
                             name, TIMEOUT_CYCLES);
                end else begin
                    check_bit(name, "stall", expect_stall(unit_e'(fld[0][2:0])), first_stall);
                    check_idx(name, "rd", fld[4][4:0], to_wb_o.rd);
                    check_word(name, "result_rd", fld[17], to_wb_o.result_rd);
                    check_word(name, "result_pc", fld[18], to_wb_o.result_pc);
                    check_bit(name, "taken", fld[19][0], to_wb_o.branch_taken);
                end
            end

            if (!ok) begin
                errors++;
                abort = 1'b1;
            end
            if (errors == 0) begin
                $display("test %s ok", name);
            end else begin
                $display("test %s failed", name);
                tests_failed++;
            end
        end

        from_rr_i.valid = 1'b0;
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && tests_run > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tests/exe_props.sv
module exe_props (
    input logic             clk_i,
    input logic             rst_i,
    input logic             stall_i,
    input exe_pkg::wb_req_t wb_req_i,
    input exe_pkg::wb_rsp_t wb_rsp_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Master closes the cycle right after the slave answers
    ack_ends_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_rsp_i.ack |=> !wb_req_i.stb)
        else $error("Wishbone stb still high in the cycle after ack");

    // Request frozen while the slave holds off ack
    req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_req_i.stb && !wb_rsp_i.ack |=> $stable(wb_req_i.adr) && $stable(wb_req_i.dat))
        else $error("Wishbone adr or dat changed before ack");

    ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else $error("Wishbone ack high in two consecutive cycles");

    // Stage comes out of reset idle
    idle_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(rst_i) |-> !stall_i && !wb_req_i.cyc && !wb_req_i.stb)
        else $error("stall_o or Wishbone cycle active right after reset");

endmodule

bind exe_top exe_props u_exe_props (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .stall_i  (stall_o),
    .wb_req_i (wb_o),
    .wb_rsp_i (wb_i)
);

// File: design/exe_subsys.sv
module exe_subsys #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   kill_i,
    input  exe_pkg::rr_exe_instr_t from_rr_i,
    input  exe_pkg::wb_exe_instr_t from_wb_i,
    output exe_pkg::exe_wb_instr_t to_wb_o,
    output logic                   stall_o
);
    import exe_pkg::*;

    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    exe_top u_exe_top (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .kill_i    (kill_i),
        .from_rr_i (from_rr_i),
        .from_wb_i (from_wb_i),
        .to_wb_o   (to_wb_o),
        .stall_o   (stall_o),
        .wb_o      (wb_req),
        .wb_i      (wb_rsp)
    );

    // Single slave on the data bus
    dmem_wb #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem_wb (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .wb_i  (wb_req),
        .wb_o  (wb_rsp)
    );

endmodule

// File: design/dmem_wb.sv
module dmem_wb #(
    parameter int DMEM_WORDS = 256
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  exe_pkg::wb_req_t wb_i,
    output exe_pkg::wb_rsp_t wb_o
);
    import exe_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    word_t            mem [DMEM_WORDS];
    word_t            rdata_q;
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    logic             req;

    // Word index wraps at the RAM depth
    assign idx = IDX_W'(wb_i.adr[XLEN-1:2] % DMEM_WORDS);
    assign req = wb_i.cyc && wb_i.stb && !ack_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            if (wb_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdata_q;

endmodule

// File: design/exe_top.sv
module exe_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   kill_i,
    input  exe_pkg::rr_exe_instr_t from_rr_i,
    input  exe_pkg::wb_exe_instr_t from_wb_i,
    output exe_pkg::exe_wb_instr_t to_wb_o,
    output logic                   stall_o,
    output exe_pkg::wb_req_t       wb_o,
    input  exe_pkg::wb_rsp_t       wb_i
);
    import exe_pkg::*;

    word_t rs1_byp;
    word_t rs2_byp;
    word_t op_a;
    word_t op_b;
    word_t alu_result;
    word_t mul_result;
    word_t div_result;
    word_t mem_result;
    word_t br_pc;
    word_t br_link;
    logic  br_taken;
    logic  mul_busy;
    logic  mul_done;
    logic  div_busy;
    logic  div_done;
    logic  lsu_busy;
    logic  lsu_done;
    logic  mul_start;
    logic  div_start;
    logic  lsu_start;

    // ------------------------------------------------------------------
    // Bypass from write-back, x0 never forwarded
    // ------------------------------------------------------------------
    assign rs1_byp = (from_wb_i.valid && from_rr_i.rs1 != '0 && from_rr_i.rs1 == from_wb_i.rd)
                   ? from_wb_i.data : from_rr_i.data_rs1;
    assign rs2_byp = (from_wb_i.valid && from_rr_i.rs2 != '0 && from_rr_i.rs2 == from_wb_i.rd)
                   ? from_wb_i.data : from_rr_i.data_rs2;

    assign op_a = from_rr_i.use_pc  ? from_rr_i.pc  : rs1_byp;
    assign op_b = from_rr_i.use_imm ? from_rr_i.imm : rs2_byp;

    assign mul_start = from_rr_i.valid && from_rr_i.unit == UNIT_MUL && !mul_busy && !mul_done;
    assign div_start = from_rr_i.valid && from_rr_i.unit == UNIT_DIV && !div_busy && !div_done;
    assign lsu_start = from_rr_i.valid && from_rr_i.unit == UNIT_MEM && !lsu_busy && !lsu_done;

    alu u_alu (
        .a_i      (op_a),
        .b_i      (op_b),
        .op_i     (from_rr_i.op),
        .result_o (alu_result)
    );

    branch_unit u_branch_unit (
        .op_i        (from_rr_i.op),
        .pc_i        (from_rr_i.pc),
        .rs1_i       (rs1_byp),
        .rs2_i       (rs2_byp),
        .imm_i       (from_rr_i.imm),
        .taken_o     (br_taken),
        .result_pc_o (br_pc),
        .link_o      (br_link)
    );

    mul_unit u_mul_unit (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .kill_i   (kill_i),
        .start_i  (mul_start),
        .op_i     (from_rr_i.op),
        .a_i      (rs1_byp),
        .b_i      (rs2_byp),
        .result_o (mul_result),
        .busy_o   (mul_busy),
        .done_o   (mul_done)
    );

    div_unit u_div_unit (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .kill_i   (kill_i),
        .start_i  (div_start),
        .op_i     (from_rr_i.op),
        .dvnd_i   (rs1_byp),
        .dvsr_i   (rs2_byp),
        .result_o (div_result),
        .busy_o   (div_busy),
        .done_o   (div_done)
    );

    lsu_wb u_lsu_wb (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .kill_i       (kill_i),
        .start_i      (lsu_start),
        .op_i         (from_rr_i.op),
        .size_i       (from_rr_i.mem_size),
        .unsigned_i   (from_rr_i.mem_unsigned),
        .base_i       (rs1_byp),
        .offset_i     (from_rr_i.imm),
        .store_data_i (rs2_byp),
        .wb_o         (wb_o),
        .wb_i         (wb_i),
        .load_data_o  (mem_result),
        .busy_o       (lsu_busy),
        .done_o       (lsu_done)
    );

    // ------------------------------------------------------------------
    // Stall and write-back result
    // ------------------------------------------------------------------
    always_comb begin
        case (from_rr_i.unit)
            UNIT_MUL: stall_o = from_rr_i.valid && !mul_done;
            UNIT_DIV: stall_o = from_rr_i.valid && !div_done;
            UNIT_MEM: stall_o = from_rr_i.valid && !lsu_done;
            default:  stall_o = 1'b0;
        endcase
    end

    always_comb begin
        to_wb_o.valid        = from_rr_i.valid && !stall_o;
        to_wb_o.rd           = from_rr_i.rd;
        to_wb_o.result_pc    = '0;
        to_wb_o.branch_taken = 1'b0;
        case (from_rr_i.unit)
            UNIT_MUL: to_wb_o.result_rd = mul_result;
            UNIT_DIV: to_wb_o.result_rd = div_result;
            UNIT_MEM: to_wb_o.result_rd = mem_result;
            UNIT_BRANCH: begin
                to_wb_o.result_rd    = br_link;
                to_wb_o.result_pc    = br_pc;
                to_wb_o.branch_taken = br_taken;
            end
            default: to_wb_o.result_rd = alu_result;
        endcase
    end

endmodule

// File: design/lsu_wb.sv
module lsu_wb (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                kill_i,
    input  logic                start_i,
    input  exe_pkg::op_e        op_i,
    input  exe_pkg::mem_size_e  size_i,
    input  logic                unsigned_i,
    input  exe_pkg::word_t      base_i,
    input  exe_pkg::word_t      offset_i,
    input  exe_pkg::word_t      store_data_i,
    output exe_pkg::wb_req_t    wb_o,
    input  exe_pkg::wb_rsp_t    wb_i,
    output exe_pkg::word_t      load_data_o,
    output logic                busy_o,
    output logic                done_o
);
    import exe_pkg::*;

    word_t      addr;
    logic [3:0] sel;
    word_t      wdata;
    logic       cyc_q;
    logic       we_q;
    word_t      adr_q;
    word_t      dat_q;
    logic [3:0] sel_q;
    mem_size_e  size_q;
    logic       uns_q;
    word_t      lane;
    word_t      ext;

    assign addr = base_i + offset_i;

    // Byte lanes and replicated store data
    always_comb begin
        case (size_i)
            MEM_B: begin
                sel   = 4'b0001 << addr[1:0];
                wdata = {4{store_data_i[7:0]}};
            end
            MEM_H: begin
                sel   = 4'b0011 << {addr[1], 1'b0};
                wdata = {2{store_data_i[15:0]}};
            end
            default: begin
                sel   = 4'b1111;
                wdata = store_data_i;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            cyc_q <= 1'b0;
        end else if (cyc_q && wb_i.ack) begin
            cyc_q <= 1'b0;
        end else if (start_i && !cyc_q) begin
            cyc_q <= 1'b1;
        end
    end

    // Request held steady until ack
    always_ff @(posedge clk_i) begin
        if (start_i && !cyc_q) begin
            adr_q  <= addr;
            we_q   <= op_i == STORE;
            dat_q  <= wdata;
            sel_q  <= sel;
            size_q <= size_i;
            uns_q  <= unsigned_i;
        end
    end

    assign wb_o.cyc = cyc_q && !kill_i;
    assign wb_o.stb = cyc_q && !kill_i;
    assign wb_o.we  = we_q;
    assign wb_o.adr = adr_q;
    assign wb_o.dat = dat_q;
    assign wb_o.sel = sel_q;

    assign lane = wb_i.dat >> {adr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            MEM_B:   ext = {{24{!uns_q && lane[7]}}, lane[7:0]};
            MEM_H:   ext = {{16{!uns_q && lane[15]}}, lane[15:0]};
            default: ext = lane;
        endcase
    end

    assign load_data_o = we_q ? '0 : ext;
    assign busy_o      = cyc_q;
    assign done_o      = cyc_q && wb_i.ack && !kill_i;

endmodule

// File: design/div_unit.sv
module div_unit (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           kill_i,
    input  logic           start_i,
    input  exe_pkg::op_e   op_i,
    input  exe_pkg::word_t dvnd_i,
    input  exe_pkg::word_t dvsr_i,
    output exe_pkg::word_t result_o,
    output logic           busy_o,
    output logic           done_o
);
    import exe_pkg::*;

    word_t         quo_q;
    word_t         rem_q;
    word_t         dvsr_q;
    logic [4:0]    cnt_q;
    logic          busy_q;
    logic          done_q;
    logic          quo_neg_q;
    logic          rem_neg_q;
    op_e           op_q;
    logic          accept;
    logic          is_signed;
    logic          dvsr_zero;
    logic [XLEN:0] rem_sh;
    logic [XLEN:0] diff;
    word_t         quo_fix;
    word_t         rem_fix;

    assign accept    = start_i && !busy_q && !done_q;
    assign is_signed = (op_i == DIV) || (op_i == REM);
    assign dvsr_zero = dvsr_i == '0;

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= (busy_q && cnt_q == 5'd31) || (accept && dvsr_zero);
            if (busy_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == 5'd31) begin
                    busy_q <= 1'b0;
                end
            end else if (accept && !dvsr_zero) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
        end
    end

    // Next dividend bit moves into the partial remainder
    assign rem_sh = {rem_q, quo_q[XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvsr_q};

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q <= op_i;
            if (dvsr_zero) begin
                // Quotient all ones, remainder is the dividend
                quo_q     <= '1;
                rem_q     <= dvnd_i;
                quo_neg_q <= 1'b0;
                rem_neg_q <= 1'b0;
            end else begin
                quo_q     <= (is_signed && dvnd_i[XLEN-1]) ? -dvnd_i : dvnd_i;
                rem_q     <= '0;
                dvsr_q    <= (is_signed && dvsr_i[XLEN-1]) ? -dvsr_i : dvsr_i;
                quo_neg_q <= is_signed && (dvnd_i[XLEN-1] ^ dvsr_i[XLEN-1]);
                rem_neg_q <= is_signed && dvnd_i[XLEN-1];
            end
        end else if (busy_q) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // Overflow case falls out of the magnitude path unchanged
    assign quo_fix  = quo_neg_q ? -quo_q : quo_q;
    assign rem_fix  = rem_neg_q ? -rem_q : rem_q;
    assign result_o = (op_q == DIV || op_q == DIVU) ? quo_fix : rem_fix;
    assign busy_o   = busy_q;
    assign done_o   = done_q;

endmodule

// File: design/mul_unit.sv
module mul_unit (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           kill_i,
    input  logic           start_i,
    input  exe_pkg::op_e   op_i,
    input  exe_pkg::word_t a_i,
    input  exe_pkg::word_t b_i,
    output exe_pkg::word_t result_o,
    output logic           busy_o,
    output logic           done_o
);
    import exe_pkg::*;

    logic [2*XLEN-1:0] acc_q;
    logic [2*XLEN-1:0] mcand_q;
    logic [2*XLEN-1:0] product;
    word_t             mplr_q;
    logic [4:0]        cnt_q;
    logic              busy_q;
    logic              done_q;
    logic              neg_q;
    op_e               op_q;
    logic              accept;
    logic              a_neg;
    logic              b_neg;

    // No new request in the completion cycle
    assign accept = start_i && !busy_q && !done_q;

    // Sign only matters for the signed high variants
    assign a_neg = a_i[XLEN-1] && (op_i == MULH || op_i == MULHSU);
    assign b_neg = b_i[XLEN-1] && (op_i == MULH);

    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= busy_q && (cnt_q == 5'd31);
            if (busy_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == 5'd31) begin
                    busy_q <= 1'b0;
                end
            end else if (accept) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
        end
    end

    // Shift-add on magnitudes
    always_ff @(posedge clk_i) begin
        if (accept) begin
            acc_q   <= '0;
            mcand_q <= {{XLEN{1'b0}}, (a_neg ? -a_i : a_i)};
            mplr_q  <= b_neg ? -b_i : b_i;
            neg_q   <= a_neg ^ b_neg;
            op_q    <= op_i;
        end else if (busy_q) begin
            if (mplr_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q <= mcand_q << 1;
            mplr_q  <= mplr_q >> 1;
        end
    end

    assign product  = neg_q ? -acc_q : acc_q;
    assign result_o = (op_q == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
    assign busy_o   = busy_q;
    assign done_o   = done_q;

endmodule

// File: design/branch_unit.sv
module branch_unit (
    input  exe_pkg::op_e   op_i,
    input  exe_pkg::word_t pc_i,
    input  exe_pkg::word_t rs1_i,
    input  exe_pkg::word_t rs2_i,
    input  exe_pkg::word_t imm_i,
    output logic           taken_o,
    output exe_pkg::word_t result_pc_o,
    output exe_pkg::word_t link_o
);
    import exe_pkg::*;

    word_t target;

    always_comb begin
        case (op_i)
            BEQ:     taken_o = rs1_i == rs2_i;
            BNE:     taken_o = rs1_i != rs2_i;
            BLT:     taken_o = $signed(rs1_i) < $signed(rs2_i);
            BGE:     taken_o = $signed(rs1_i) >= $signed(rs2_i);
            BLTU:    taken_o = rs1_i < rs2_i;
            BGEU:    taken_o = rs1_i >= rs2_i;
            JAL,
            JALR:    taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    // jalr is register relative and drops bit 0
    assign target      = (op_i == JALR) ? ((rs1_i + imm_i) & ~word_t'(1)) : (pc_i + imm_i);
    assign link_o      = pc_i + word_t'(4);
    assign result_pc_o = taken_o ? target : link_o;

endmodule

// File: design/alu.sv
module alu (
    input  exe_pkg::word_t a_i,
    input  exe_pkg::word_t b_i,
    input  exe_pkg::op_e   op_i,
    output exe_pkg::word_t result_o
);
    import exe_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            AND:     result_o = a_i & b_i;
            OR:      result_o = a_i | b_i;
            XOR:     result_o = a_i ^ b_i;
            SLL:     result_o = a_i << shamt;
            SRL:     result_o = a_i >> shamt;
            SRA:     result_o = word_t'($signed(a_i) >>> shamt);
            SLT:     result_o = word_t'($signed(a_i) < $signed(b_i));
            SLTU:    result_o = word_t'(a_i < b_i);
            // Immediate already shifted into the upper bits
            LUI:     result_o = b_i;
            // Operand a carries the PC here
            AUIPC:   result_o = a_i + b_i;
            default: result_o = '0;
        endcase
    end

endmodule

// File: design/exe_pkg.sv
package exe_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV,
        UNIT_BRANCH,
        UNIT_MEM
    } unit_e;

    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI, AUIPC,
        MUL, MULH, MULHU, MULHSU,
        DIV, DIVU, REM, REMU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        LOAD, STORE
    } op_e;

    typedef enum logic [1:0] {
        MEM_B,
        MEM_H,
        MEM_W
    } mem_size_e;

    // ------------------------------------------------------------------
    // Pipeline records
    // ------------------------------------------------------------------

    typedef struct packed {
        logic      valid;
        unit_e     unit;
        op_e       op;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     data_rs1;
        word_t     data_rs2;
        word_t     imm;
        word_t     pc;
        logic      use_imm;
        logic      use_pc;
        mem_size_e mem_size;
        logic      mem_unsigned;
    } rr_exe_instr_t;

    // Forwarding source from write-back
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_exe_instr_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result_rd;
        word_t    result_pc;
        logic     branch_taken;
    } exe_wb_instr_t;

    // ------------------------------------------------------------------
    // Wishbone classic
    // ------------------------------------------------------------------

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

endpackage
